/* testbench/mem_tests.txt */
# name addr wdata wstrb exp_rdata exp_err   (hex fields, exp_err decimal 0 or 1)
# tests named hold_* keep valid high for extra cycles after ready
wr_full_m0     00000000 12345678 f 00000000 0
rd_full_m0     00000000 00000000 0 12345678 0
wr_full2_m0    00000000 cafef00d f 12345678 0
rd_full2_m0    00000000 00000000 0 cafef00d 0
wr_base_m0     00000010 a1b2c3d4 f 00000000 0
wr_byte0       00000010 000000ee 1 a1b2c3d4 0
wr_byte2       00000010 00550000 4 a1b2c3ee 0
wr_half_hi     00000010 77880000 c a155c3ee 0
wr_half_lo     00000010 00009911 3 7788c3ee 0
wr_byte1       00000010 ffff44ff 2 77889911 0
rd_merge       00000010 00000000 0 77884411 0
wr_m0_w8       00000020 0000aaaa f 00000000 0
wr_m1_w8       01000020 0000bbbb f 00000000 0
rd_m0_w8       00000020 00000000 0 0000aaaa 0
rd_m1_w8       01000020 00000000 0 0000bbbb 0
rd_m1_w0       01000000 00000000 0 00000000 0
unmapped_rd    02000000 00000000 0 deadbeef 1
unmapped_wr    ff000040 11111111 f deadbeef 1
rd_after_err   00000000 00000000 0 cafef00d 0
hold_inc_b0    01000030 00000001 1 00000000 0
hold_inc_b1    01000030 00000100 2 00000001 0
hold_inc_b2    01000030 00020000 4 00000101 0
hold_inc_b0b   01000030 00000002 1 00020101 0
hold_unmapped  80000000 00000000 0 deadbeef 1
rd_held        01000030 00000000 0 00020102 0
rd_lo1         00000011 00000000 0 77884411 0
rd_lo2         00000012 00000000 0 77884411 0
rd_lo3         01000033 00000000 0 00020102 0

/* compile.f */
+incdir+design
design/mem_bus_pkg.sv
design/mem_periph_pkg.sv
design/mem_unpack.sv
design/mem_block.sv
design/bus_watchdog.sv
design/bus_fabric.sv
design/mem_subsys.sv
testbench/tb_mem_subsys.sv

/* Makefile */
# Verilator build and run for the memory bus segment
# Override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_mem_subsys.sv */
// Testbench for the memory bus segment
// Replays testbench/mem_tests.txt through a single bus master and checks each response
// Run from the project root so that the test file path resolves
`timescale 1ns/1ps
`include "mem_bus_defs.svh"

module tb_mem_subsys;
    import mem_bus_pkg::*;

    // Extra cycles a hold_* test keeps valid high after ready
    localparam int    HOLD_CYCLES = 3;
    // Cycles valid stays low between tests before the random gap
    localparam int    IDLE_CYCLES = 2;
    // Longest wait for one ready beyond the fabric timeout
    localparam int    READY_LIMIT = `WDOG_LIMIT + 10;
    localparam string TEST_FILE   = "testbench/mem_tests.txt";

    logic        clk;
    logic        rst;
    mem_fwd_t    req;
    mem_ret_t    rsp;

    // Test table as read from the data file
    string       t_name[$];
    bus_addr_t   t_addr[$];
    bus_data_t   t_wdata[$];
    bus_strb_t   t_wstrb[$];
    bus_data_t   t_rdata[$];
    logic        t_err[$];
    bit          tests_loaded = 1'b0;
    logic [15:0] lfsr;

    mem_subsys u_mem_subsys (.clk(clk), .rst(rst), .req(req), .rsp(rsp));

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Failure reporting and compare tasks
    // ------------------------------------------------------------
    task report_failure();
        $display("Some tests failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
        if (exp !== act) begin
            $display("Error: test %s read data expected %h actual %h", name, exp, act);
            report_failure();
        end
    endtask

    // Error flag is whether the response took the timeout path
    task automatic check_error(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Error: test %s error flag expected %0b actual %0b", name, exp, act);
            report_failure();
        end
    endtask

    // ------------------------------------------------------------
    // Galois LFSR x^16 + x^14 + x^13 + x^11 + 1 for the idle gaps
    // ------------------------------------------------------------
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic lsb;
        lsb = s[0];
        s   = s >> 1;
        if (lsb) s = s ^ 16'hB400;
        return s;
    endfunction

    // One step per bit taken
    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val  = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // ------------------------------------------------------------
    // Test file reader that skips lines starting with #
    // ------------------------------------------------------------
    task automatic load_tests();
        int        fd;
        int        cnt;
        int        err;
        string     line;
        string     name;
        bus_addr_t addr;
        bus_data_t wdata;
        bus_strb_t wstrb;
        bus_data_t rdata;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the test file %s", TEST_FILE);
            report_failure();
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() < 2 || line.getc(0) == "#") continue;
                cnt = $sscanf(line, "%s %h %h %h %h %d", name, addr, wdata, wstrb, rdata, err);
                if (cnt != 6) begin
                    $display("Malformed line in the test file: %s", line);
                    report_failure();
                end
                t_name.push_back(name);
                t_addr.push_back(addr);
                t_wdata.push_back(wdata);
                t_wstrb.push_back(wstrb);
                t_rdata.push_back(rdata);
                t_err.push_back(err != 0);
            end
            $fclose(fd);
            tests_loaded = 1'b1;
        end
    endtask

    // Ready is sampled mid-cycle and the task returns just after the pulse
    // waited counts the cycles spent before ready showed up
    task automatic wait_ready(input string name, output bus_data_t rdata, output int waited);
        waited = 0;
        @(negedge clk);
        while (!rsp.ready && waited < READY_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!rsp.ready) begin
            $display("No ready from the DUT for test %s", name);
            report_failure();
        end
        rdata = rsp.rdata;
        @(posedge clk);
        #1;
    endtask

    // Any ready here would be a second pulse for the same request
    task automatic watch_idle(input string name, input int n);
        repeat (n) begin
            @(negedge clk);
            if (rsp.ready) begin
                $display("Unexpected extra ready pulse in test %s", name);
                report_failure();
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_test(input int idx);
        string     name;
        bus_data_t rdata;
        int        waited;
        int        gap;
        name      = t_name[idx];
        req.valid = 1'b1;
        req.addr  = t_addr[idx];
        req.wdata = t_wdata[idx];
        req.wstrb = t_wstrb[idx];
        wait_ready(name, rdata, waited);
        check_data(name, t_rdata[idx], rdata);
        // Timeout path answers only after the watchdog limit
        // a mapped access answers within a few pipeline cycles
        check_error(name, t_err[idx], waited >= `WDOG_LIMIT);
        // Back-pressure test keeps valid up past the pulse
        if (name.substr(0, 3) == "hold") watch_idle(name, HOLD_CYCLES);
        req = '0;
        take_bits(2, gap);
        watch_idle(name, IDLE_CYCLES + gap);
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        rst  = 1'b1;
        req  = '0;
        lfsr = 16'd12771;
        load_tests();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < t_name.size(); i++) begin
            run_test(i);
        end
        $display("All tests passed");
        $finish;
    end

    // Run limit scales with the number of tests in the file
    initial begin
        int budget;
        wait (tests_loaded);
        budget = t_name.size() * (`WDOG_LIMIT + 20) + 10;
        repeat (budget) @(posedge clk);
        $display("Timeout, no response within %0d cycles for %0d tests", budget, t_name.size());
        report_failure();
    end

endmodule

/* design/mem_subsys.sv */
// Memory bus segment top level
// Fabric, watchdog and two block RAMs at regions 0x00 and 0x01
`timescale 1ns/1ps

module mem_subsys (
    input  logic                  clk,
    input  logic                  rst,
    input  mem_bus_pkg::mem_fwd_t req,
    output mem_bus_pkg::mem_ret_t rsp
);
    import mem_bus_pkg::*;

    // Request broadcast to every peripheral
    mem_fwd_t periph_fwd;
    // Per-peripheral returns
    mem_ret_t ret0;
    mem_ret_t ret1;
    // Timeout handshake
    logic     wdog_run;
    logic     wdog_expired;

    bus_fabric u_fabric (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .rsp          (rsp),
        .periph_fwd   (periph_fwd),
        .ret0         (ret0),
        .ret1         (ret1),
        .wdog_run     (wdog_run),
        .wdog_expired (wdog_expired)
    );

    bus_watchdog u_wdog (.clk(clk), .rst(rst), .run(wdog_run), .expired(wdog_expired));

    mem_block #(.BASE_ADDR(8'h00)) u_mem0 (.clk(clk), .rst(rst), .fwd(periph_fwd), .ret(ret0));

    mem_block #(.BASE_ADDR(8'h01)) u_mem1 (.clk(clk), .rst(rst), .fwd(periph_fwd), .ret(ret1));

endmodule

/* design/bus_fabric.sv */
// Single-master bus fabric
// Forwards one request at a time to all peripherals, ORs their returns
// and gives the master exactly one ready per request
`timescale 1ns/1ps
`include "mem_bus_defs.svh"

module bus_fabric (
    input  logic                  clk,
    input  logic                  rst,
    input  mem_bus_pkg::mem_fwd_t req,
    output mem_bus_pkg::mem_ret_t rsp,
    output mem_bus_pkg::mem_fwd_t periph_fwd,
    input  mem_bus_pkg::mem_ret_t ret0,
    input  mem_bus_pkg::mem_ret_t ret1,
    output logic                  wdog_run,
    input  logic                  wdog_expired
);
    import mem_bus_pkg::*;
    import mem_periph_pkg::*;

    fab_state_t state;
    logic       fwd_valid;
    bus_addr_t  fwd_addr;
    bus_data_t  fwd_wdata;
    bus_strb_t  fwd_wstrb;
    bus_data_t  rdata_q;
    mem_ret_t   merged;

    // Idle peripherals return zeros so OR is enough
    assign merged = ret0 | ret1;

    // ------------------------------------------------------------
    // Request FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            fwd_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: if (req.valid) begin
                    fwd_valid <= 1'b1;
                    state     <= WAIT;
                end
                WAIT: if (merged.ready || wdog_expired) begin
                    fwd_valid <= 1'b0;
                    state     <= RESPOND;
                end
                RESPOND: state <= RETIRE;
                // Hold here until the master drops valid
                default: if (!req.valid) state <= IDLE;
            endcase
        end
    end

    // Request payload and response data
    always_ff @(posedge clk) begin
        if (state == IDLE && req.valid) begin
            fwd_addr  <= req.addr;
            fwd_wdata <= req.wdata;
            fwd_wstrb <= req.wstrb;
        end
        if (state == WAIT) begin
            // Real answer wins over a same-cycle timeout
            rdata_q <= merged.ready ? merged.rdata : `BUS_ERR_WORD;
        end
    end

    assign periph_fwd = '{valid: fwd_valid, addr: fwd_addr, wdata: fwd_wdata, wstrb: fwd_wstrb};
    assign rsp        = '{ready: (state == RESPOND), rdata: rdata_q};
    assign wdog_run   = (state == WAIT);

    // Ready to the master only ever follows the wait phase
    assert property (@(posedge clk) disable iff (rst) rsp.ready |-> $past(state) == WAIT);
    // Address decode in the blocks must be exclusive
    assert property (@(posedge clk) disable iff (rst) !(ret0.ready && ret1.ready));

endmodule

/* design/bus_watchdog.sv */
// Wait-cycle counter for the bus fabric
// Counts while run is high and flags expiry at WDOG_LIMIT
`timescale 1ns/1ps
`include "mem_bus_defs.svh"

module bus_watchdog (
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic expired
);

    localparam int CNT_W = $clog2(`WDOG_LIMIT + 1);
    localparam logic [CNT_W-1:0] LIMIT = CNT_W'(`WDOG_LIMIT);

    logic [CNT_W-1:0] count;

    // ------------------------------------------------------------
    // Saturating counter
    // ------------------------------------------------------------
    // Cleared whenever the fabric is not waiting
    always_ff @(posedge clk) begin
        if (rst || !run) begin
            count <= '0;
        end else if (count != LIMIT) begin
            count <= count + 1'b1;
        end
    end

    // High in the cycle the count reaches the limit
    assign expired = (count == LIMIT);

    // Expiry can only follow a cycle of waiting
    assert property (@(posedge clk) disable iff (rst) expired |-> $past(run));

endmodule

/* design/mem_block.sv */
// Byte-strobed block RAM peripheral on the packed memory bus
// Answers only addresses whose bits 31:24 match BASE_ADDR
// Read data of a write is the word before the write
`timescale 1ns/1ps
`include "mem_bus_defs.svh"

module mem_block #(
    parameter mem_periph_pkg::base_addr_t BASE_ADDR = 8'h00
) (
    input  logic                  clk,
    input  logic                  rst,
    input  mem_bus_pkg::mem_fwd_t fwd,
    output mem_bus_pkg::mem_ret_t ret
);
    import mem_bus_pkg::*;
    import mem_periph_pkg::*;

    localparam int MEM_WORDS = `MEM_BYTES / 4;
    localparam int IDX_W     = $clog2(MEM_WORDS);

    logic       valid;
    bus_addr_t  addr;
    bus_data_t  wdata;
    bus_strb_t  wstrb;
    bus_data_t  rdata_q;
    logic       ready_q;
    logic       ready_d;
    word_addr_t word_addr;
    base_addr_t region;
    logic       accept;

    bus_data_t mem [0:MEM_WORDS-1];

    mem_unpack u_unpack (
        .clk   (clk),
        .fwd   (fwd),
        .ret   (ret),
        .valid (valid),
        .addr  (addr),
        .wdata (wdata),
        .wstrb (wstrb),
        .ready (ready_q),
        .rdata (rdata_q)
    );

    assign word_addr = addr[23:2];
    assign region    = addr[31:24];
    // Blocked during the ready pulse and the recovery cycle after it
    assign accept    = valid && !ready_q && !ready_d && (region == BASE_ADDR);

    // Memory starts as all zeros
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // ------------------------------------------------------------
    // Read old word and write strobed bytes in the same clock
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= mem[word_addr[IDX_W-1:0]];
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) mem[word_addr[IDX_W-1:0]][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    // Ready pulse, then one dummy cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q <= 1'b0;
            ready_d <= 1'b0;
        end else begin
            ready_q <= accept;
            ready_d <= ready_q;
        end
    end

    // Returned ready is a single pulse per request
    assert property (@(posedge clk) disable iff (rst) ret.ready |=> !ret.ready);

endmodule

/* design/mem_unpack.sv */
// Peripheral bus adapter
// Splits the forward word into fields and registers the return word once
`timescale 1ns/1ps

module mem_unpack (
    input  logic                  clk,
    // Packed bus side
    input  mem_bus_pkg::mem_fwd_t fwd,
    output mem_bus_pkg::mem_ret_t ret,
    // Peripheral core side
    output logic                  valid,
    output mem_bus_pkg::bus_addr_t addr,
    output mem_bus_pkg::bus_data_t wdata,
    output mem_bus_pkg::bus_strb_t wstrb,
    input  logic                  ready,
    input  mem_bus_pkg::bus_data_t rdata
);
    import mem_bus_pkg::*;

    mem_ret_t ret_q;

    // ------------------------------------------------------------
    // Forward path, plain field split
    // ------------------------------------------------------------
    assign valid = fwd.valid;
    assign addr  = fwd.addr;
    assign wdata = fwd.wdata;
    assign wstrb = fwd.wstrb;

    // ------------------------------------------------------------
    // Return path, one flop stage
    // ------------------------------------------------------------
    // rdata forced to zero outside the ready pulse
    // so the fabric can OR all returns together
    always_ff @(posedge clk) begin
        ret_q.ready <= ready;
        ret_q.rdata <= ready ? rdata : '0;
    end

    assign ret = ret_q;

endmodule

/* design/mem_periph_pkg.sv */
// Types used on the peripheral side of the bus fabric
// Address slicing for decode and the fabric request FSM
package mem_periph_pkg;

    // Region number, taken from address bits 31:24
    typedef logic [7:0]  base_addr_t;

    // Word index inside a region, address bits 23:2
    typedef logic [21:0] word_addr_t;

    // ------------------------------------------------------------
    // Fabric request FSM
    // ------------------------------------------------------------
    // IDLE     wait for a request from the master
    // WAIT     request sits on the peripheral bus
    // RESPOND  one-cycle ready to the master
    // RETIRE   wait for the master to drop valid
    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        RESPOND,
        RETIRE
    } fab_state_t;

endpackage

/* design/mem_bus_pkg.sv */
// Types of the packed PicoRV32-style memory bus
// Forward word goes master to peripheral, return word comes back
package mem_bus_pkg;

    // Byte address, bits 1:0 are ignored by all peripherals
    typedef logic [31:0] bus_addr_t;
    // One data word
    typedef logic [31:0] bus_data_t;
    // Byte strobes, all zero marks a read
    typedef logic [3:0]  bus_strb_t;

    // ------------------------------------------------------------
    // Forward word, 69 bits
    // ------------------------------------------------------------
    typedef struct packed {
        logic      valid;
        bus_addr_t addr;
        bus_data_t wdata;
        bus_strb_t wstrb;
    } mem_fwd_t;

    // Return word, 33 bits
    // ready is a one-cycle pulse, rdata valid with it
    typedef struct packed {
        logic      ready;
        bus_data_t rdata;
    } mem_ret_t;

endpackage

/* design/mem_bus_defs.svh */
// Build-wide constants for the memory bus segment
// Include in any RTL file that needs memory size, watchdog limit or error word
`ifndef MEM_BUS_DEFS_SVH
`define MEM_BUS_DEFS_SVH

// ------------------------------------------------------------
// Memory blocks
// ------------------------------------------------------------
// Size of each block RAM in bytes, a multiple of 4
`define MEM_BYTES 1024

// ------------------------------------------------------------
// Fabric timeout
// ------------------------------------------------------------
// Waiting cycles before an unanswered request is ended
`define WDOG_LIMIT 8
// Read word returned when the watchdog ends a request
`define BUS_ERR_WORD 32'hDEAD_BEEF

`endif
